/* verilog/core_pkg.sv */
/*
 * Core package: bus and LSU structs, opcode encodings and sizing constants
 */
package core_pkg;

  ////////////////////////////////////////
  // Sizing
  ////////////////////////////////////////

  // Data and address width
  localparam int XLEN = 32;
  // Register index width
  localparam int REG_AW = 5;
  // First fetch address
  localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0000;
  // Credits held after reset
  localparam int BUS_CREDITS = 2;
  // Instruction buffer depth
  localparam int FETCH_DEPTH = 4;
  // Counter widths, sized to hold the full value
  localparam int CREDIT_W = $clog2(BUS_CREDITS + 1);
  localparam int FETCH_CNT_W = $clog2(FETCH_DEPTH + 1);

  ////////////////////////////////////////
  // Bus
  ////////////////////////////////////////

  // One request on the shared bus
  typedef struct packed {
    logic            valid;
    logic            we;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } bus_req_t;

  // One in-order response, stores included
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] rdata;
  } bus_rsp_t;

  // Owner of an outstanding request
  typedef enum logic {
    FETCH = 1'b0,
    LSU   = 1'b1
  } bus_src_e;

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////

  // RV32I major opcodes of the subset
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  // Access handed from execute to the LSU
  typedef struct packed {
    logic              valid;
    logic              we;
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   wdata;
    logic [REG_AW-1:0] rd;
  } lsu_req_t;

endpackage

/* verilog/sync_fifo.sv */
/*
 * Synchronous FIFO, circular buffer with a type-parameter payload
 */
`timescale 1ns/100ps

module sync_fifo #(
  parameter int  DEPTH     = 2,
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  // Pointer and level widths
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] count_q;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Storage, written at the tail
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wptr_q] <= data_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (pop_i) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      // Level moves only on a lone push or a lone pop
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Head word, read combinationally
  assign data_o  = mem_q[rptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));

  // Users size their traffic so neither side ever hits a wall
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

/* verilog/fetch_unit.sv */
/*
 * Fetch unit: sequential prefetcher filling a small instruction buffer
 */
`timescale 1ns/100ps

module fetch_unit (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  output logic                      fetch_req_valid_o,
  output logic [core_pkg::XLEN-1:0] fetch_req_addr_o,
  input  logic                      fetch_gnt_i,
  input  core_pkg::bus_rsp_t        fetch_rsp_i,
  output logic                      instr_valid_o,
  output logic [core_pkg::XLEN-1:0] instr_o,
  input  logic                      instr_pop_i
);

  import core_pkg::*;

  logic [XLEN-1:0]        pc_q;
  // Granted fetches still waiting for their word
  logic [FETCH_CNT_W-1:0] outstanding_q;
  // Words sitting in the buffer
  logic [FETCH_CNT_W-1:0] buffered_q;
  logic                   buf_empty;

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // Ask only while a buffer slot is left for every word in flight
  assign fetch_req_valid_o = (outstanding_q + buffered_q) < FETCH_CNT_W'(FETCH_DEPTH);
  assign fetch_req_addr_o  = pc_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q          <= BOOT_ADDR;
      outstanding_q <= '0;
      buffered_q    <= '0;
    end else begin
      // No branches, PC only walks forward
      if (fetch_gnt_i) begin
        pc_q <= pc_q + XLEN'(4);
      end
      outstanding_q <= outstanding_q + FETCH_CNT_W'(fetch_gnt_i)
                       - FETCH_CNT_W'(fetch_rsp_i.valid);
      buffered_q    <= buffered_q + FETCH_CNT_W'(fetch_rsp_i.valid)
                       - FETCH_CNT_W'(instr_pop_i);
    end
  end

  ////////////////////////////////////////
  // Instruction buffer
  ////////////////////////////////////////

  // Word enters in its response cycle
  sync_fifo #(
    .DEPTH     ( FETCH_DEPTH      ),
    .payload_t ( logic [XLEN-1:0] )
  ) u_instr_buf (
    .clk_i   ( clk_i             ),
    .rst_n_i ( rst_n_i           ),
    .push_i  ( fetch_rsp_i.valid ),
    .data_i  ( fetch_rsp_i.rdata ),
    .pop_i   ( instr_pop_i       ),
    .data_o  ( instr_o           ),
    .empty_o ( buf_empty         ),
    .full_o  (                   )
  );

  assign instr_valid_o = !buf_empty;

endmodule

/* verilog/bus_arbiter.sv */
/*
 * Bus arbiter: shares the credit-based bus between fetch and LSU,
 * LSU first, and steers the in-order responses back to their owners
 */
`timescale 1ns/100ps

module bus_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Fetch requester
  input  logic                      fetch_req_valid_i,
  input  logic [core_pkg::XLEN-1:0] fetch_req_addr_i,
  output logic                      fetch_gnt_o,
  output core_pkg::bus_rsp_t        fetch_rsp_o,
  // LSU requester
  input  core_pkg::bus_req_t        lsu_req_i,
  output logic                      lsu_gnt_o,
  output core_pkg::bus_rsp_t        lsu_rsp_o,
  // Shared bus
  output core_pkg::bus_req_t        bus_req_o,
  input  logic                      bus_credit_i,
  input  core_pkg::bus_rsp_t        bus_rsp_i
);

  import core_pkg::*;

  logic [CREDIT_W-1:0] credit_cnt_q;
  bus_req_t            bus_req_q;
  logic                credit_avail;
  logic                any_gnt;
  bus_src_e            gnt_src;
  bus_src_e            rsp_src;

  ////////////////////////////////////////
  // Credits and grant
  ////////////////////////////////////////

  // The registered request spends its credit this cycle, so look past it
  assign credit_avail = credit_cnt_q > CREDIT_W'(bus_req_q.valid);

  // LSU ahead of fetch
  assign lsu_gnt_o   = credit_avail && lsu_req_i.valid;
  assign fetch_gnt_o = credit_avail && fetch_req_valid_i && !lsu_req_i.valid;
  assign any_gnt     = lsu_gnt_o || fetch_gnt_o;
  assign gnt_src     = lsu_gnt_o ? LSU : FETCH;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_cnt_q <= CREDIT_W'(BUS_CREDITS);
      bus_req_q    <= '0;
    end else begin
      // Spend on the bus, refill on each returned pulse
      credit_cnt_q <= credit_cnt_q - CREDIT_W'(bus_req_q.valid)
                      + CREDIT_W'(bus_credit_i);
      // Winner goes out one cycle after its grant
      if (lsu_gnt_o) begin
        bus_req_q <= lsu_req_i;
      end else if (fetch_gnt_o) begin
        bus_req_q <= '{valid: 1'b1, we: 1'b0, addr: fetch_req_addr_i, wdata: '0};
      end else begin
        bus_req_q <= '0;
      end
    end
  end

  assign bus_req_o = bus_req_q;

  ////////////////////////////////////////
  // Response routing
  ////////////////////////////////////////

  // Owners queue at grant, one pop per response
  sync_fifo #(
    .DEPTH     ( BUS_CREDITS ),
    .payload_t ( bus_src_e   )
  ) u_owner_fifo (
    .clk_i   ( clk_i           ),
    .rst_n_i ( rst_n_i         ),
    .push_i  ( any_gnt         ),
    .data_i  ( gnt_src         ),
    .pop_i   ( bus_rsp_i.valid ),
    .data_o  ( rsp_src         ),
    .empty_o (                 ),
    .full_o  (                 )
  );

  // Data fans out to both, valid only to the owner
  assign fetch_rsp_o = '{valid: bus_rsp_i.valid && (rsp_src == FETCH),
                         rdata: bus_rsp_i.rdata};
  assign lsu_rsp_o   = '{valid: bus_rsp_i.valid && (rsp_src == LSU),
                         rdata: bus_rsp_i.rdata};

  // Every request on the bus is covered by a credit
  a_credit_on_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_req_o.valid |-> (credit_cnt_q != '0));
  // Memory never hands back more than it was given
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_cnt_q <= CREDIT_W'(BUS_CREDITS));

endmodule

/* verilog/register_file.sv */
/*
 * Register file: x1..x31, two read ports, ALU and load write ports
 */
`timescale 1ns/100ps

module register_file (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [core_pkg::REG_AW-1:0] raddr_a_i,
  input  logic [core_pkg::REG_AW-1:0] raddr_b_i,
  output logic [core_pkg::XLEN-1:0]   rdata_a_o,
  output logic [core_pkg::XLEN-1:0]   rdata_b_o,
  // ALU results
  input  logic                        we_a_i,
  input  logic [core_pkg::REG_AW-1:0] waddr_a_i,
  input  logic [core_pkg::XLEN-1:0]   wdata_a_i,
  // Load data
  input  logic                        we_b_i,
  input  logic [core_pkg::REG_AW-1:0] waddr_b_i,
  input  logic [core_pkg::XLEN-1:0]   wdata_b_i
);

  import core_pkg::*;

  // No storage behind x0
  logic [XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < 32; i++) begin
        // Ports never target a register in the same cycle
        if (we_a_i && (waddr_a_i == REG_AW'(i))) begin
          regs_q[i] <= wdata_a_i;
        end
        if (we_b_i && (waddr_b_i == REG_AW'(i))) begin
          regs_q[i] <= wdata_b_i;
        end
      end
    end
  end

  // x0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* verilog/exec_unit.sv */
/*
 * Execute unit: single-stage decode, ALU and writeback for ADDI, ADD, SUB,
 * with LW and SW handed to the LSU
 */
`timescale 1ns/100ps

module exec_unit (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Instruction buffer
  input  logic                        instr_valid_i,
  input  logic [core_pkg::XLEN-1:0]   instr_i,
  output logic                        instr_pop_o,
  // Register file
  output logic [core_pkg::REG_AW-1:0] rs1_addr_o,
  output logic [core_pkg::REG_AW-1:0] rs2_addr_o,
  input  logic [core_pkg::XLEN-1:0]   rs1_data_i,
  input  logic [core_pkg::XLEN-1:0]   rs2_data_i,
  output logic                        rf_we_o,
  output logic [core_pkg::REG_AW-1:0] rf_waddr_o,
  output logic [core_pkg::XLEN-1:0]   rf_wdata_o,
  // LSU
  output core_pkg::lsu_req_t          lsu_req_o,
  input  logic                        lsu_busy_i
);

  import core_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic            alu_we;
  logic [XLEN-1:0] alu_res;
  logic            is_mem;
  logic            mem_we;
  logic [XLEN-1:0] mem_addr;

  ////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////

  assign opcode     = opcode_e'(instr_i[6:0]);
  assign funct3     = instr_i[14:12];
  assign funct7     = instr_i[31:25];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];
  // Sign-extended I and S immediates
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////

  always_comb begin
    alu_we   = 1'b0;
    alu_res  = '0;
    is_mem   = 1'b0;
    mem_we   = 1'b0;
    mem_addr = rs1_data_i + imm_i;
    case (opcode)
      // ADDI only
      OP_IMM: begin
        if (funct3 == 3'b000) begin
          alu_we  = 1'b1;
          alu_res = rs1_data_i + imm_i;
        end
      end
      // ADD and SUB
      OP: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          alu_we  = 1'b1;
          alu_res = rs1_data_i + rs2_data_i;
        end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
          alu_we  = 1'b1;
          alu_res = rs1_data_i - rs2_data_i;
        end
      end
      // LW
      LOAD: begin
        is_mem = (funct3 == 3'b010);
      end
      // SW
      STORE: begin
        is_mem   = (funct3 == 3'b010);
        mem_we   = 1'b1;
        mem_addr = rs1_data_i + imm_s;
      end
      // Anything else retires as a no-op
      default: ;
    endcase
  end

  // Whole unit waits on a busy LSU, so a pending load's rd is never read early
  assign instr_pop_o = instr_valid_i && !lsu_busy_i;

  // ALU writeback in the pop cycle
  assign rf_we_o    = instr_pop_o && alu_we;
  assign rf_waddr_o = instr_i[11:7];
  assign rf_wdata_o = alu_res;

  assign lsu_req_o = '{valid: instr_pop_o && is_mem,
                       we:    mem_we,
                       addr:  mem_addr,
                       wdata: rs2_data_i,
                       rd:    instr_i[11:7]};

  // LSU takes the access and holds busy from the next cycle
  a_lsu_takes_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lsu_req_o.valid |=> lsu_busy_i);

endmodule

/* verilog/load_store_unit.sv */
/*
 * Load/store unit: holds one access, puts it on the bus, returns load data
 */
`timescale 1ns/100ps

module load_store_unit (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  core_pkg::lsu_req_t          lsu_req_i,
  output logic                        lsu_busy_o,
  // Arbiter side
  output core_pkg::bus_req_t          bus_req_o,
  input  logic                        gnt_i,
  input  core_pkg::bus_rsp_t          rsp_i,
  // Load writeback
  output logic                        ld_we_o,
  output logic [core_pkg::REG_AW-1:0] ld_rd_o,
  output logic [core_pkg::XLEN-1:0]   ld_data_o
);

  import core_pkg::*;

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,
    LSU_RSP
  } lsu_state_e;

  lsu_state_e state_q;
  lsu_req_t   req_q;

  // Accept, wait for grant, wait for response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= LSU_IDLE;
    end else begin
      case (state_q)
        LSU_IDLE: if (lsu_req_i.valid) state_q <= LSU_REQ;
        LSU_REQ:  if (gnt_i) state_q <= LSU_RSP;
        LSU_RSP:  if (rsp_i.valid) state_q <= LSU_IDLE;
        default:  state_q <= LSU_IDLE;
      endcase
    end
  end

  // Access held until its response
  always_ff @(posedge clk_i) begin
    if (state_q == LSU_IDLE && lsu_req_i.valid) begin
      req_q <= lsu_req_i;
    end
  end

  // Busy through the response cycle as well
  assign lsu_busy_o = (state_q != LSU_IDLE);

  assign bus_req_o = '{valid: (state_q == LSU_REQ),
                       we:    req_q.we,
                       addr:  req_q.addr,
                       wdata: req_q.wdata};

  // Load result in the response cycle, stores just finish
  assign ld_we_o   = (state_q == LSU_RSP) && rsp_i.valid && !req_q.we;
  assign ld_rd_o   = req_q.rd;
  assign ld_data_o = rsp_i.rdata;

  // Arbiter only steers a response here once the access is on the bus
  a_rsp_when_waiting: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_i.valid |-> (state_q == LSU_RSP));

endmodule

/* verilog/core_top.sv */
/*
 * Core top level: fetch, execute, register file and LSU on one shared bus
 */
`timescale 1ns/100ps

module core_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  output core_pkg::bus_req_t bus_req_o,
  input  logic               bus_credit_i,
  input  core_pkg::bus_rsp_t bus_rsp_i
);

  import core_pkg::*;

  // Fetch and arbiter
  logic              fetch_req_valid;
  logic [XLEN-1:0]   fetch_req_addr;
  logic              fetch_gnt;
  bus_rsp_t          fetch_rsp;
  // LSU and arbiter
  bus_req_t          lsu_bus_req;
  logic              lsu_gnt;
  bus_rsp_t          lsu_rsp;
  // Fetch to execute
  logic              instr_valid;
  logic [XLEN-1:0]   instr;
  logic              instr_pop;
  // Register file
  logic [REG_AW-1:0] rs1_addr;
  logic [REG_AW-1:0] rs2_addr;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  logic              rf_we;
  logic [REG_AW-1:0] rf_waddr;
  logic [XLEN-1:0]   rf_wdata;
  // Execute to LSU and load result
  lsu_req_t          lsu_req;
  logic              lsu_busy;
  logic              ld_we;
  logic [REG_AW-1:0] ld_rd;
  logic [XLEN-1:0]   ld_data;

  ////////////////////////////////////////
  // Front end
  ////////////////////////////////////////

  fetch_unit u_fetch (
    .clk_i             ( clk_i           ),
    .rst_n_i           ( rst_n_i         ),
    .fetch_req_valid_o ( fetch_req_valid ),
    .fetch_req_addr_o  ( fetch_req_addr  ),
    .fetch_gnt_i       ( fetch_gnt       ),
    .fetch_rsp_i       ( fetch_rsp       ),
    .instr_valid_o     ( instr_valid     ),
    .instr_o           ( instr           ),
    .instr_pop_i       ( instr_pop       )
  );

  ////////////////////////////////////////
  // Execute and register file
  ////////////////////////////////////////

  exec_unit u_exec (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .instr_valid_i ( instr_valid ),
    .instr_i       ( instr       ),
    .instr_pop_o   ( instr_pop   ),
    .rs1_addr_o    ( rs1_addr    ),
    .rs2_addr_o    ( rs2_addr    ),
    .rs1_data_i    ( rs1_data    ),
    .rs2_data_i    ( rs2_data    ),
    .rf_we_o       ( rf_we       ),
    .rf_waddr_o    ( rf_waddr    ),
    .rf_wdata_o    ( rf_wdata    ),
    .lsu_req_o     ( lsu_req     ),
    .lsu_busy_i    ( lsu_busy    )
  );

  // Port a from the ALU, port b from loads
  register_file u_rf (
    .clk_i     ( clk_i    ),
    .rst_n_i   ( rst_n_i  ),
    .raddr_a_i ( rs1_addr ),
    .raddr_b_i ( rs2_addr ),
    .rdata_a_o ( rs1_data ),
    .rdata_b_o ( rs2_data ),
    .we_a_i    ( rf_we    ),
    .waddr_a_i ( rf_waddr ),
    .wdata_a_i ( rf_wdata ),
    .we_b_i    ( ld_we    ),
    .waddr_b_i ( ld_rd    ),
    .wdata_b_i ( ld_data  )
  );

  ////////////////////////////////////////
  // Data side and shared bus
  ////////////////////////////////////////

  load_store_unit u_lsu (
    .clk_i      ( clk_i       ),
    .rst_n_i    ( rst_n_i     ),
    .lsu_req_i  ( lsu_req     ),
    .lsu_busy_o ( lsu_busy    ),
    .bus_req_o  ( lsu_bus_req ),
    .gnt_i      ( lsu_gnt     ),
    .rsp_i      ( lsu_rsp     ),
    .ld_we_o    ( ld_we       ),
    .ld_rd_o    ( ld_rd       ),
    .ld_data_o  ( ld_data     )
  );

  bus_arbiter u_arbiter (
    .clk_i             ( clk_i           ),
    .rst_n_i           ( rst_n_i         ),
    .fetch_req_valid_i ( fetch_req_valid ),
    .fetch_req_addr_i  ( fetch_req_addr  ),
    .fetch_gnt_o       ( fetch_gnt       ),
    .fetch_rsp_o       ( fetch_rsp       ),
    .lsu_req_i         ( lsu_bus_req     ),
    .lsu_gnt_o         ( lsu_gnt         ),
    .lsu_rsp_o         ( lsu_rsp         ),
    .bus_req_o         ( bus_req_o       ),
    .bus_credit_i      ( bus_credit_i    ),
    .bus_rsp_i         ( bus_rsp_i       )
  );

endmodule

/* verification/core_tb_model.svh */
/*
 * Reference ISA model and random program generator for the core testbench
 */
`ifndef CORE_TB_MODEL_SVH
`define CORE_TB_MODEL_SVH

// Program and data layout
localparam int          PROG_LEN   = 64;
localparam logic [31:0] DATA_BASE  = 32'h0000_0100;
localparam int          DATA_WORDS = 16;
localparam logic [31:0] NOP_WORD   = 32'h0000_0013;

logic [31:0] prog [PROG_LEN];
// Expected data accesses, in program order
logic        exp_we    [PROG_LEN];
logic [31:0] exp_addr  [PROG_LEN];
logic [31:0] exp_wdata [PROG_LEN];
int          n_acc;
logic [31:0] exp_mem   [DATA_WORDS];

// Initial data word, mixes every address bit
function automatic logic [31:0] fill_word(input logic [31:0] addr);
  return addr ^ {addr[15:0], addr[31:16]} ^ 32'hc3a5_0f1e;
endfunction

task automatic gen_program();
  logic [1:0]  kind;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [11:0] imm;
  logic [31:0] off;
  for (int i = 0; i < PROG_LEN; i++) begin
    kind = 2'(rand_bits(2));
    rd   = 5'(rand_bits(3) % 7) + 5'd1;
    rs1  = 5'(rand_bits(3));
    rs2  = 5'(rand_bits(3));
    // Tail stays ALU only, so loads finish before fetch reaches the data region
    if (i >= PROG_LEN - 8 && kind >= 2'd2) begin
      kind = 2'd0;
    end
    off = DATA_BASE + (rand_bits(4) << 2);
    case (kind)
      2'd0: begin
        imm     = 12'(rand_bits(12));
        prog[i] = {imm, rs1, 3'b000, rd, 7'b0010011};
      end
      2'd1: prog[i] = {(rand_bits(1) != 0) ? 7'h20 : 7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
      2'd2: prog[i] = {off[11:0], 5'd0, 3'b010, rd, 7'b0000011};
      default: prog[i] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
    endcase
  end
endtask

// In-order execution straight from the RV32I encodings
task automatic run_model();
  logic [31:0] regs [32];
  logic [31:0] w;
  logic [31:0] immi;
  logic [31:0] imms;
  logic [31:0] addr;
  int          idx;
  for (int k = 0; k < 32; k++) begin
    regs[k] = '0;
  end
  for (int k = 0; k < DATA_WORDS; k++) begin
    exp_mem[k] = fill_word(DATA_BASE + 32'(k * 4));
  end
  n_acc = 0;
  for (int i = 0; i < PROG_LEN; i++) begin
    w    = prog[i];
    immi = {{20{w[31]}}, w[31:20]};
    imms = {{20{w[31]}}, w[31:25], w[11:7]};
    case (w[6:0])
      7'b0010011: regs[w[11:7]] = regs[w[19:15]] + immi;
      7'b0110011: begin
        if (w[30]) regs[w[11:7]] = regs[w[19:15]] - regs[w[24:20]];
        else regs[w[11:7]] = regs[w[19:15]] + regs[w[24:20]];
      end
      7'b0000011: begin
        addr = regs[w[19:15]] + immi;
        idx  = int'((addr - DATA_BASE) >> 2);
        exp_we[n_acc]    = 1'b0;
        exp_addr[n_acc]  = addr;
        exp_wdata[n_acc] = '0;
        n_acc++;
        regs[w[11:7]] = exp_mem[idx];
      end
      default: begin
        addr = regs[w[19:15]] + imms;
        idx  = int'((addr - DATA_BASE) >> 2);
        exp_we[n_acc]    = 1'b1;
        exp_addr[n_acc]  = addr;
        exp_wdata[n_acc] = regs[w[24:20]];
        n_acc++;
        exp_mem[idx] = regs[w[24:20]];
      end
    endcase
    // x0 stays zero
    regs[0] = '0;
  end
endtask

`endif

/* verification/core_tb.sv */
/*
 * Core testbench driving a random program through a credit-based memory
 * model with variable latency, checked against an in-order ISA model
 */
`timescale 1ns/100ps

module core_tb;

  import core_pkg::*;

  logic     clk;
  logic     rst_n;
  bus_req_t bus_req;
  logic     bus_credit;
  bus_rsp_t bus_rsp;

  logic [31:0] lfsr_q = 32'h81d1_b5ed;

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  `include "core_tb_model.svh"

  // Worst case per instruction plus prefetch tail
  localparam int TIMEOUT_CYCLES = PROG_LEN * 12 + 200;

  ////////////////////////////////////////
  // Memory state
  ////////////////////////////////////////

  logic [31:0] data_mem [DATA_WORDS];
  logic [31:0] pend_data [$];
  int          pend_due [$];
  int          cyc;
  int          last_due;
  int          acc_idx;
  logic [31:0] fetch_next;
  int          outstanding;
  logic        seen_first;
  logic        fixed_delay;
  logic        timed_out;
  int          errors;
  int          tests_run;
  int          tests_failed;

  core_top u_dut (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .bus_req_o    ( bus_req    ),
    .bus_credit_i ( bus_credit ),
    .bus_rsp_i    ( bus_rsp    )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic reset_memory();
    acc_idx     = 0;
    fetch_next  = BOOT_ADDR;
    outstanding = 0;
    seen_first  = 1'b0;
    last_due    = -1;
    pend_data.delete();
    pend_due.delete();
    for (int k = 0; k < DATA_WORDS; k++) begin
      data_mem[k] = fill_word(DATA_BASE + 32'(k * 4));
    end
  endtask

  // Load or store against the next expected access
  task automatic check_data_access(output logic [31:0] rdata);
    int idx;
    rdata = '0;
    idx   = int'((bus_req.addr - DATA_BASE) >> 2);
    if (acc_idx >= n_acc) begin
      $display("Unexpected data access at %0t to address %h", $time, bus_req.addr);
      errors++;
    end else begin
      if (bus_req.we != exp_we[acc_idx]) begin
        $display("Error at %0t: bus_req_o.we = %b, expected %b", $time, bus_req.we,
                 exp_we[acc_idx]);
        errors++;
      end
      if (bus_req.addr != exp_addr[acc_idx]) begin
        $display("Error at %0t: bus_req_o.addr = %h, expected %h", $time, bus_req.addr,
                 exp_addr[acc_idx]);
        errors++;
      end
      if (bus_req.we && bus_req.wdata != exp_wdata[acc_idx]) begin
        $display("Error at %0t: bus_req_o.wdata = %h, expected %h", $time, bus_req.wdata,
                 exp_wdata[acc_idx]);
        errors++;
      end
      acc_idx++;
    end
    if (idx < 0 || idx >= DATA_WORDS || bus_req.addr < DATA_BASE) begin
      $display("Data access at %0t falls outside the data region", $time);
      errors++;
    end else if (bus_req.we) begin
      data_mem[idx] = bus_req.wdata;
    end else begin
      rdata = data_mem[idx];
    end
  endtask

  task automatic take_request();
    logic [31:0] rdata;
    int          due;
    if (outstanding >= BUS_CREDITS) begin
      $display("Request at %0t was issued with no credit left", $time);
      errors++;
    end
    outstanding++;
    if (!seen_first) begin
      seen_first = 1'b1;
      if (bus_req.we || bus_req.addr != BOOT_ADDR) begin
        $display("Error at %0t: first bus_req_o.addr = %h, expected read at %h", $time,
                 bus_req.addr, BOOT_ADDR);
        errors++;
      end
    end
    // Reads below the data region, or once all data accesses are done, are fetches
    if (!bus_req.we && (bus_req.addr < DATA_BASE || acc_idx >= n_acc)) begin
      if (bus_req.addr != fetch_next) begin
        $display("Error at %0t: fetch bus_req_o.addr = %h, expected %h", $time,
                 bus_req.addr, fetch_next);
        errors++;
      end
      fetch_next = fetch_next + 32'd4;
      rdata = (bus_req.addr < DATA_BASE) ? prog[bus_req.addr[7:2]] : NOP_WORD;
    end else begin
      check_data_access(rdata);
    end
    // At most one in-order response per cycle
    due = cyc + (fixed_delay ? 3 : int'(rand_bits(2)));
    if (due <= last_due) begin
      due = last_due + 1;
    end
    last_due = due;
    pend_data.push_back(rdata);
    pend_due.push_back(due);
  endtask

  ////////////////////////////////////////
  // Memory process
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      if (bus_req.valid) begin
        $display("Bus request issued during reset at %0t", $time);
        errors++;
      end
      bus_rsp    <= '0;
      bus_credit <= 1'b0;
      reset_memory();
    end else begin
      cyc = cyc + 1;
      if (bus_req.valid) begin
        take_request();
      end
      // Credit goes back with its response
      if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
        bus_rsp    <= '{valid: 1'b1, rdata: pend_data.pop_front()};
        bus_credit <= 1'b1;
        void'(pend_due.pop_front());
        outstanding--;
      end else begin
        bus_rsp    <= '0;
        bus_credit <= 1'b0;
      end
    end
  end

  function automatic logic all_done();
    return (acc_idx == n_acc) && (fetch_next >= DATA_BASE + 32'(DATA_WORDS * 4));
  endfunction

  task automatic run_test(input string name, input logic fixed);
    int start;
    int err0;
    err0        = errors;
    fixed_delay = fixed;
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    start = cyc;
    while (!all_done() && (cyc - start) < TIMEOUT_CYCLES) begin
      @(posedge clk);
    end
    tests_run++;
    if (!all_done()) begin
      $display("Timeout in test %s after %0d cycles", name, TIMEOUT_CYCLES);
      timed_out = 1'b1;
      tests_failed++;
    end else begin
      // Data region after every load and store
      for (int k = 0; k < DATA_WORDS; k++) begin
        if (data_mem[k] != exp_mem[k]) begin
          $display("Error at %0t: data_mem[%0d] = %h, expected %h", $time, k,
                   data_mem[k], exp_mem[k]);
          errors++;
        end
      end
      if (errors != err0) begin
        tests_failed++;
        $display("Test %s: %0d errors", name, errors - err0);
      end else begin
        $display("Test %s: ok", name);
      end
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    bus_credit   = 1'b0;
    bus_rsp      = '0;
    cyc          = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    fixed_delay  = 1'b0;
    timed_out    = 1'b0;
    gen_program();
    run_model();
    run_test("random latency", 1'b0);
    // Same program with the slowest credit return
    if (!timed_out) begin
      run_test("fixed latency 3", 1'b1);
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+verification
verilog/core_pkg.sv
verilog/sync_fifo.sv
verilog/fetch_unit.sv
verilog/bus_arbiter.sv
verilog/register_file.sv
verilog/exec_unit.sv
verilog/load_store_unit.sv
verilog/core_top.sv
verification/core_tb.sv

/* Makefile */
SRCS := $(wildcard verilog/*.sv) verification/core_tb.sv verification/core_tb_model.svh

.PHONY: run clean

obj_dir/Vcore_tb: $(SRCS) verilog.f
	verilator --binary --assert --top-module core_tb -f verilog.f -Mdir obj_dir -o Vcore_tb

run: obj_dir/Vcore_tb
	@out="$$(./obj_dir/Vcore_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
